/* dma_lite.f */
dma_pkg.sv
mem_bus_pkg.sv
read_src_engine.sv
dma_data_fifo.sv
write_dest_fsm.sv
dma_lite_top.sv
tb_dma_lite.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the dma_lite testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f dma_lite.f --top-module tb_dma_lite -o tb_dma_lite \
   && ./obj_dir/tb_dma_lite | tee /dev/stderr | grep -qx "NO ERRORS" \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "Simulation failed"; exit 1; }

/* tb_dma_lite.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma_lite testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_dma_lite
   import dma_pkg::*, mem_bus_pkg::*;
();

   localparam int NUM_TRANSFERS  = 40;
   localparam int MAX_LEN        = 100;
   // Back-pressure roughly halves throughput so five cycles per beat is ample
   localparam int TIMEOUT_CYCLES = NUM_TRANSFERS * MAX_LEN * 5;

   logic              clk;
   logic              reset_n;
   logic              desc_valid;
   t_dma_descriptor   desc;
   t_src_rd_req       src_req;
   logic [DATA_W-1:0] src_rd_data;
   logic              src_rd_valid;
   logic              aw_valid;
   t_aw_chan          aw;
   logic              aw_ready;
   logic              w_valid;
   t_w_chan           w;
   logic              w_ready;
   logic              b_valid;
   t_resp             b_resp;
   logic              clear_error;
   logic              done;
   t_dma_status       status;

   int                seed = 32'h84b8752a;
   int                cycle = 0;
   int                errors = 0;
   int                checks = 0;
   int                start_cycle = 0;
   int                done_cycle = 0;
   int                done_cnt = 0;
   int                aw_idx = 0;
   int                last_idx = 0;
   int                beat = 0;
   int                exp_beats = 0;
   int                err_burst = -1;
   bit                bp = 1'b0;
   t_dma_descriptor   cur_desc;
   t_aw_chan          cur_aw;
   logic              rd_pending = 1'b0;
   logic [ADDR_W-1:0] rd_pending_addr = '0;
   logic              w_held_valid = 1'b0;
   t_w_chan           w_held;
   logic [DATA_W-1:0] dmem [logic [ADDR_W-1:0]];
   int                b_due [$];
   t_resp             b_kind [$];

   dma_lite_top dut0 (
      .clk          (clk),
      .reset_n      (reset_n),
      .desc_valid   (desc_valid),
      .desc         (desc),
      .src_req      (src_req),
      .src_rd_data  (src_rd_data),
      .src_rd_valid (src_rd_valid),
      .aw_valid     (aw_valid),
      .aw           (aw),
      .aw_ready     (aw_ready),
      .w_valid      (w_valid),
      .w            (w),
      .w_ready      (w_ready),
      .b_valid      (b_valid),
      .b_resp       (b_resp),
      .clear_error  (clear_error),
      .done         (done),
      .status       (status)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Source memory contents mix every address bit
   function automatic logic [DATA_W-1:0] src_word(input logic [ADDR_W-1:0] addr);
      return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5ac3_0f1e;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      int r;
      r = $random(seed);
      return lo + (r & 32'h7fff_ffff) % (hi - lo + 1);
   endfunction

   function automatic t_dma_descriptor rand_desc(input int min_len);
      t_dma_descriptor d;
      d.src_addr  = ADDR_W'(rand_range(0, 'h3f_ffff) * BEAT_BYTES);
      d.dest_addr = ADDR_W'(rand_range(0, 'h3f_ffff) * BEAT_BYTES);
      d.length    = LENGTH_W'(rand_range(min_len, MAX_LEN));
      return d;
   endfunction

   task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_aw(input string name, input t_aw_chan exp, input t_aw_chan act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected addr %h len %0d, actual addr %h len %0d",
                  name, exp.addr, exp.len, act.addr, act.len);
      end
   endtask

   task automatic check_status(input string name, input t_dma_status exp,
                               input t_dma_status act);
      string exp_s;
      string act_s;
      checks++;
      if (act !== exp) begin
         errors++;
         exp_s = $sformatf("busy %b err %b state %h clk %0d beats %0d", exp.busy,
                           exp.stopped_on_error, exp.wr_state, exp.clk_cnt, exp.valid_cnt);
         act_s = $sformatf("busy %b err %b state %h clk %0d beats %0d", act.busy,
                           act.stopped_on_error, act.wr_state, act.clk_cnt, act.valid_cnt);
         $display("Fail %s: expected %s, actual %s", name, exp_s, act_s);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Fail %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   // One clock of the memory models at the falling edge
   task automatic step();
      int                rem;
      t_aw_chan          exp_aw;
      logic [ADDR_W-1:0] waddr;
      @(negedge clk);
      cycle++;
      src_rd_valid    = rd_pending;
      src_rd_data     = src_word(rd_pending_addr);
      rd_pending      = src_req.rd_valid;
      rd_pending_addr = src_req.addr;
      aw_ready = bp ? (rand_range(0, 3) != 0) : 1'b1;
      w_ready  = bp ? (rand_range(0, 1) != 0) : 1'b1;
      b_valid  = 1'b0;
      if (b_due.size() > 0 && b_due[0] <= cycle) begin
         b_valid = 1'b1;
         b_resp  = b_kind.pop_front();
         b_due.delete(0);
      end
      if (w_held_valid) begin
         check_flag("w_valid hold", 1'b1, w_valid);
         check_word("w data hold", w_held.data, w.data);
         check_flag("w last hold", w_held.last, w.last);
      end
      w_held_valid = w_valid && !w_ready;
      w_held       = w;
      if (aw_valid && aw_ready) begin
         rem         = int'(cur_desc.length) - aw_idx * MAX_BURST;
         exp_beats   = (rem > MAX_BURST) ? MAX_BURST : rem;
         exp_aw.addr = cur_desc.dest_addr + ADDR_W'(aw_idx * BURST_BYTES);
         exp_aw.len  = AXI_LEN_W'(exp_beats - 1);
         check_aw("aw burst", exp_aw, aw);
         cur_aw = aw;
         beat   = 0;
         aw_idx++;
      end
      if (w_valid && w_ready) begin
         waddr       = cur_aw.addr + ADDR_W'(beat * BEAT_BYTES);
         dmem[waddr] = w.data;
         check_flag("w last", beat == exp_beats - 1, w.last);
         beat++;
         if (w.last) begin
            // Response 1 to 4 cycles after the last beat in burst order
            b_due.push_back(cycle + rand_range(1, 4));
            if (last_idx == err_burst)
               b_kind.push_back(SLVERR);
            else
               b_kind.push_back(OKAY);
            last_idx++;
         end
      end
      if (done) begin
         done_cnt++;
         done_cycle = cycle;
      end
   endtask

   task automatic begin_transfer(input t_dma_descriptor d);
      cur_desc = d;
      aw_idx   = 0;
      last_idx = 0;
      done_cnt = 0;
      dmem.delete();
      desc        = d;
      desc_valid  = 1'b1;
      start_cycle = cycle;
      step();
      desc_valid = 1'b0;
   endtask

   task automatic finish_transfer(input t_dma_descriptor d);
      t_dma_status       exp_st;
      logic [ADDR_W-1:0] addr;
      while (done_cnt == 0)
         step();
      // Idle cycles catch a repeated done pulse
      repeat (6)
         step();
      check_flag("single done", 1'b1, done_cnt == 1);
      exp_st.busy             = 1'b0;
      exp_st.stopped_on_error = 1'b0;
      exp_st.wr_state         = IDLE;
      exp_st.clk_cnt          = CNT_W'(done_cycle - start_cycle - 1);
      exp_st.valid_cnt        = CNT_W'(d.length);
      check_status("status after done", exp_st, status);
      check_flag("clk_cnt bound", 1'b1, status.clk_cnt >= CNT_W'(d.length) + CNT_W'(2));
      for (int i = 0; i < int'(d.length); i++) begin
         addr = d.dest_addr + ADDR_W'(i * BEAT_BYTES);
         if (!dmem.exists(addr)) begin
            errors++;
            $display("Destination word at %h was never written", addr);
         end else begin
            check_word("dest data", src_word(d.src_addr + ADDR_W'(i * BEAT_BYTES)), dmem[addr]);
         end
      end
   endtask

   task automatic run_transfer(input t_dma_descriptor d);
      begin_transfer(d);
      finish_transfer(d);
   endtask

   task automatic report_and_finish();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   endtask

   initial begin
      while (cycle < TIMEOUT_CYCLES)
         @(posedge clk);
      errors++;
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      report_and_finish();
   end

   initial begin
      t_dma_descriptor d;
      t_dma_descriptor d2;
      reset_n      = 1'b0;
      desc_valid   = 1'b0;
      desc         = '0;
      src_rd_data  = '0;
      src_rd_valid = 1'b0;
      aw_ready     = 1'b0;
      w_ready      = 1'b0;
      b_valid      = 1'b0;
      b_resp       = OKAY;
      clear_error  = 1'b0;
      repeat (3)
         step();
      reset_n = 1'b1;
      repeat (2)
         step();

      // Data and burst checks with back-pressure on every other transfer
      for (int n = 0; n < NUM_TRANSFERS; n++) begin
         bp = n[0];
         run_transfer(rand_desc(1));
      end
      bp = 1'b0;

      // SLVERR on one chosen burst
      d         = rand_desc(3 * MAX_BURST);
      err_burst = rand_range(0, (int'(d.length) - 1) / MAX_BURST);
      begin_transfer(d);
      while (!status.stopped_on_error)
         step();
      repeat (10)
         step();
      check_flag("no done on error", 1'b0, done_cnt != 0);
      check_flag("busy in error", 1'b1, status.busy);
      clear_error = 1'b1;
      step();
      clear_error = 1'b0;
      step();
      check_flag("busy after clear", 1'b0, status.busy);
      err_burst = -1;
      run_transfer(rand_desc(1));

      // Second descriptor while busy is dropped
      d  = rand_desc(2 * MAX_BURST);
      d2 = rand_desc(1);
      begin_transfer(d);
      repeat (4)
         step();
      check_flag("busy while running", 1'b1, status.busy);
      desc       = d2;
      desc_valid = 1'b1;
      step();
      desc_valid = 1'b0;
      finish_transfer(d);
      check_word("dest word count", DATA_W'(d.length), DATA_W'(dmem.num()));

      report_and_finish();
   end

endmodule

/* dma_lite_top.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dma_lite top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dma_lite_top
   import dma_pkg::*, mem_bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              desc_valid,
   input  t_dma_descriptor   desc,
   output t_src_rd_req       src_req,
   input  logic [DATA_W-1:0] src_rd_data,
   input  logic              src_rd_valid,
   output logic              aw_valid,
   output t_aw_chan          aw,
   input  logic              aw_ready,
   output logic              w_valid,
   output t_w_chan           w,
   input  logic              w_ready,
   input  logic              b_valid,
   input  t_resp             b_resp,
   input  logic              clear_error,
   output logic              done,
   output t_dma_status       status
);

   logic              start;
   logic              push;
   logic [DATA_W-1:0] push_data;
   logic              pop;
   logic [DATA_W-1:0] pop_data;
   logic              not_empty;
   logic              pop_seen;
   logic              abort;

   // Descriptors sent while busy are dropped
   assign start = desc_valid && !status.busy;

   read_src_engine #(
      .DEPTH (FIFO_DEPTH)
   ) u_read_src_engine (
      .clk          (clk),
      .reset_n      (reset_n),
      .start        (start),
      .desc         (desc),
      .src_req      (src_req),
      .src_rd_data  (src_rd_data),
      .src_rd_valid (src_rd_valid),
      .push         (push),
      .push_data    (push_data),
      .pop_seen     (pop_seen),
      .abort        (abort)
   );

   dma_data_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_dma_data_fifo (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .pop_data  (pop_data),
      .not_empty (not_empty),
      .pop_seen  (pop_seen),
      .flush     (abort)
   );

   write_dest_fsm u_write_dest_fsm (
      .clk         (clk),
      .reset_n     (reset_n),
      .start       (start),
      .desc        (desc),
      .not_empty   (not_empty),
      .pop_data    (pop_data),
      .pop         (pop),
      .aw_valid    (aw_valid),
      .aw          (aw),
      .aw_ready    (aw_ready),
      .w_valid     (w_valid),
      .w           (w),
      .w_ready     (w_ready),
      .b_valid     (b_valid),
      .b_resp      (b_resp),
      .clear_error (clear_error),
      .done        (done),
      .abort       (abort),
      .status      (status)
   );

endmodule

/* write_dest_fsm.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Destination write FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module write_dest_fsm
   import dma_pkg::*, mem_bus_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              start,
   input  t_dma_descriptor   desc,
   input  logic              not_empty,
   input  logic [DATA_W-1:0] pop_data,
   output logic              pop,
   output logic              aw_valid,
   output t_aw_chan          aw,
   input  logic              aw_ready,
   output logic              w_valid,
   output t_w_chan           w,
   input  logic              w_ready,
   input  logic              b_valid,
   input  t_resp             b_resp,
   input  logic              clear_error,
   output logic              done,
   output logic              abort,
   output t_dma_status       status
);

   t_wr_state              state;
   t_wr_state              next_state;
   logic [LENGTH_W-1:0]    desc_len_m1;
   logic [LENGTH_W-1:0]    len_m1;
   logic [BURST_CNT_W-1:0] num_bursts;
   logic [BURST_CNT_W-1:0] last_cnt;
   logic [BURST_CNT_W-1:0] rsp_cnt;
   logic [AXI_LEN_W:0]     burst_left;
   logic [CNT_W-1:0]       clk_cnt;
   logic [CNT_W-1:0]       valid_cnt;
   logic                   data_phase;
   logic                   aw_fire;
   logic                   w_fire;
   logic                   ok_fire;
   logic                   err_fire;
   logic                   load;
   logic                   more_bursts;
   logic                   final_burst;
   logic                   all_ok;

   assign desc_len_m1 = desc.length - LENGTH_W'(1);
   assign data_phase  = (state == FIFO_EMPTY) || (state == NOT_READY) || (state == WRITE_DATA);
   assign aw_valid    = (state == ADDR_SETUP);
   assign aw_fire     = aw_valid && aw_ready;
   assign w_fire      = w_valid && w_ready;
   assign ok_fire     = b_valid && (b_resp == OKAY);
   assign err_fire    = b_valid && (b_resp == SLVERR);
   assign abort       = (state == ERROR);

   // Next beat enters the w register once it is empty or being taken
   assign load = data_phase && (burst_left != '0) && not_empty && (!w_valid || w_ready);
   assign pop  = load;

   assign more_bursts = (last_cnt + BURST_CNT_W'(1)) < num_bursts;
   assign final_burst = (last_cnt == num_bursts - BURST_CNT_W'(1));
   assign all_ok      = (rsp_cnt + BURST_CNT_W'(ok_fire)) == num_bursts;

   always_ff @(posedge clk) begin
      if (!reset_n)
         state <= IDLE;
      else
         state <= next_state;
   end

   always_comb begin
      next_state = state;
      unique case (state)
         IDLE:
            if (start) next_state = ADDR_SETUP;
         ADDR_SETUP:
            if (aw_fire) next_state = not_empty ? WRITE_DATA : FIFO_EMPTY;
         FIFO_EMPTY, NOT_READY, WRITE_DATA:
            if (w_fire && w.last) next_state = more_bursts ? ADDR_NEXT : WAIT_FOR_RSP;
            else if (load) next_state = WRITE_DATA;
            else if (w_valid && !w_ready) next_state = NOT_READY;
            else next_state = FIFO_EMPTY;
         ADDR_NEXT:
            next_state = ADDR_SETUP;
         WAIT_FOR_RSP:
            if (all_ok) next_state = IDLE;
         ERROR:
            if (clear_error) next_state = IDLE;
         default:
            next_state = IDLE;
      endcase
      // A failed burst stops the transfer wherever it is
      if (err_fire && state != IDLE && state != ERROR)
         next_state = ERROR;
   end

   // Burst and response bookkeeping
   always_ff @(posedge clk) begin
      if (!reset_n || start) begin
         last_cnt   <= '0;
         rsp_cnt    <= '0;
         burst_left <= '0;
      end else begin
         if (w_fire && w.last)
            last_cnt <= last_cnt + BURST_CNT_W'(1);
         if (ok_fire)
            rsp_cnt <= rsp_cnt + BURST_CNT_W'(1);
         if (aw_fire)
            burst_left <= {1'b0, aw.len} + (AXI_LEN_W + 1)'(1);
         else if (load)
            burst_left <= burst_left - (AXI_LEN_W + 1)'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         len_m1     <= desc_len_m1;
         num_bursts <= {1'b0, desc_len_m1[LENGTH_W-1:AXI_LEN_W]} + BURST_CNT_W'(1);
         aw.addr    <= desc.dest_addr;
         aw.len     <= (desc_len_m1[LENGTH_W-1:AXI_LEN_W] != '0) ? '1 :
                       desc_len_m1[AXI_LEN_W-1:0];
      end else if (state == ADDR_NEXT) begin
         aw.addr <= aw.addr + ADDR_W'(BURST_BYTES);
         aw.len  <= final_burst ? len_m1[AXI_LEN_W-1:0] : '1;
      end
      if (load) begin
         w.data <= pop_data;
         w.last <= (burst_left == (AXI_LEN_W + 1)'(1));
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n)
         w_valid <= 1'b0;
      else if (load)
         w_valid <= 1'b1;
      else if (w_ready || (abort && clear_error))
         w_valid <= 1'b0;
   end

   // Done pulse and performance counters, held after done
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         done      <= 1'b0;
         clk_cnt   <= '0;
         valid_cnt <= '0;
      end else begin
         done <= (state == WAIT_FOR_RSP) && (next_state == IDLE);
         if (start) begin
            clk_cnt   <= '0;
            valid_cnt <= '0;
         end else if (state != IDLE) begin
            clk_cnt   <= clk_cnt + CNT_W'(1);
            valid_cnt <= valid_cnt + CNT_W'(w_fire);
         end
      end
   end

   assign status.busy             = (state != IDLE);
   assign status.stopped_on_error = abort;
   assign status.wr_state         = state;
   assign status.clk_cnt          = clk_cnt;
   assign status.valid_cnt        = valid_cnt;

endmodule

/* dma_data_fifo.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA data FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module dma_data_fifo
   import dma_pkg::*;
#(
   parameter int DEPTH = FIFO_DEPTH
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              push,
   input  logic [DATA_W-1:0] push_data,
   input  logic              pop,
   output logic [DATA_W-1:0] pop_data,
   output logic              not_empty,
   output logic              pop_seen,
   input  logic              flush
);

   typedef logic [$clog2(DEPTH)-1:0] t_ptr;
   typedef logic [$clog2(DEPTH):0]   t_count;

   logic [DATA_W-1:0] mem [DEPTH];
   t_ptr              wr_ptr;
   t_ptr              rd_ptr;
   t_count            count;
   logic              do_push;
   logic              do_pop;

   assign do_push   = push && (count != t_count'(DEPTH));
   assign do_pop    = pop && not_empty;
   assign not_empty = (count != '0);
   assign pop_data  = mem[rd_ptr];
   // Returns a slot to the read engine
   assign pop_seen  = do_pop;

   always_ff @(posedge clk) begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (!reset_n || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + t_ptr'(1);
         if (do_pop)
            rd_ptr <= rd_ptr + t_ptr'(1);
         count <= count + t_count'(do_push) - t_count'(do_pop);
      end
   end

endmodule

/* read_src_engine.sv */
`timescale 1ns/1ps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Source read engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module read_src_engine
   import dma_pkg::*, mem_bus_pkg::*;
#(
   parameter int DEPTH = FIFO_DEPTH
)(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              start,
   input  t_dma_descriptor   desc,
   output t_src_rd_req       src_req,
   input  logic [DATA_W-1:0] src_rd_data,
   input  logic              src_rd_valid,
   output logic              push,
   output logic [DATA_W-1:0] push_data,
   input  logic              pop_seen,
   input  logic              abort
);

   // Holds 0..DEPTH free slots
   typedef logic [$clog2(DEPTH):0] t_credit;

   logic [ADDR_W-1:0]   rd_addr;
   logic [LENGTH_W-1:0] remaining;
   t_credit             credits;
   logic                issue;

   // One read per cycle while words remain and the FIFO has room for them
   assign issue = (remaining != '0) && (credits != '0) && !abort;

   assign src_req.rd_valid = issue;
   assign src_req.addr     = rd_addr;

   // Words that come back after an abort are dropped
   assign push      = src_rd_valid && !abort;
   assign push_data = src_rd_data;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         remaining <= '0;
         credits   <= t_credit'(DEPTH);
      end else if (abort) begin
         // FIFO is flushed during the error state, so all slots come back
         remaining <= '0;
         credits   <= t_credit'(DEPTH);
      end else begin
         if (start)
            remaining <= desc.length;
         else if (issue)
            remaining <= remaining - LENGTH_W'(1);
         credits <= credits + t_credit'(pop_seen) - t_credit'(issue);
      end
   end

   always_ff @(posedge clk) begin
      if (start)
         rd_addr <= desc.src_addr;
      else if (issue)
         rd_addr <= rd_addr + ADDR_W'(BEAT_BYTES);
   end

endmodule

/* mem_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory port channel types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_bus_pkg;

   import dma_pkg::*;

   // Write response codes, AXI encoding
   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } t_resp;

   typedef struct packed {
      logic [ADDR_W-1:0]    addr;
      logic [AXI_LEN_W-1:0] len;
   } t_aw_chan;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } t_w_chan;

   // Source read request, one strobe per word
   typedef struct packed {
      logic              rd_valid;
      logic [ADDR_W-1:0] addr;
   } t_src_rd_req;

endpackage

/* dma_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DMA descriptor and status types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dma_pkg;

   localparam int DATA_W     = 32;
   localparam int ADDR_W     = 32;
   localparam int LENGTH_W   = 16;
   localparam int AXI_LEN_W  = 4;
   localparam int BEAT_BYTES = 4;
   localparam int CNT_W      = 32;
   localparam int FIFO_DEPTH = 16;

   // Beats and bytes in one full burst
   localparam int MAX_BURST   = 2 ** AXI_LEN_W;
   localparam int BURST_BYTES = BEAT_BYTES * MAX_BURST;
   // Wide enough to count every burst of the longest descriptor
   localparam int BURST_CNT_W = LENGTH_W - AXI_LEN_W + 1;

   typedef struct packed {
      logic [ADDR_W-1:0]   src_addr;
      logic [ADDR_W-1:0]   dest_addr;
      logic [LENGTH_W-1:0] length;
   } t_dma_descriptor;

   // One-hot write FSM encoding
   typedef enum logic [7:0] {
      IDLE         = 8'b0000_0001,
      ADDR_SETUP   = 8'b0000_0010,
      FIFO_EMPTY   = 8'b0000_0100,
      NOT_READY    = 8'b0000_1000,
      WRITE_DATA   = 8'b0001_0000,
      ADDR_NEXT    = 8'b0010_0000,
      WAIT_FOR_RSP = 8'b0100_0000,
      ERROR        = 8'b1000_0000
   } t_wr_state;

   typedef struct packed {
      logic             busy;
      logic             stopped_on_error;
      t_wr_state        wr_state;
      logic [CNT_W-1:0] clk_cnt;
      logic [CNT_W-1:0] valid_cnt;
   } t_dma_status;

endpackage
